/* mips_config.svh */
//*********************************************************************
// global sizing for the MIPS core
// word width covers both data and byte addresses
// register count must stay a power of two, index width derives from it
// reset PC must be word aligned
//*********************************************************************
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

`define MIPS_WORD_W    32    // data and address bits
`define MIPS_REG_CNT   32    // architectural registers
`define MIPS_PC_RESET  32'h0 // first fetch address

`endif

/* mips_pkg.sv */
//*********************************************************************
// types shared by the MIPS core
// only the kept subset of opcodes and functs is listed
// halt is the all ones word, opcode 6'h3f
//*********************************************************************
`include "mips_config.svh"

package mips_pkg;

   typedef logic [`MIPS_WORD_W-1:0] word_t;
   typedef logic [$clog2(`MIPS_REG_CNT)-1:0] regbits_t;

   typedef enum logic [5:0]
   {
      RTYPE = 6'h00,
      BEQ   = 6'h04,
      BNE   = 6'h05,
      ADDIU = 6'h09,
      ANDI  = 6'h0c,
      ORI   = 6'h0d,
      LUI   = 6'h0f,
      LW    = 6'h23,
      SW    = 6'h2b,
      HALT  = 6'h3f
   } opcode_t;

   typedef enum logic [5:0]
   {
      SLL  = 6'h00,
      ADDU = 6'h21,
      SUBU = 6'h23,
      AND  = 6'h24,
      OR   = 6'h25,
      SLT  = 6'h2a
   } funct_t;

   typedef enum logic [2:0]
   {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_SLT = 3'd4, // signed compare
      ALU_SLL = 3'd5  // also serves lui
   } aluop_t;

   // one instruction word, two field layouts
   typedef union packed
   {
      struct packed
      {
         opcode_t    opcode;
         regbits_t   rs;
         regbits_t   rt;
         regbits_t   rd;
         logic [4:0] shamt;
         funct_t     funct;
      } r;
      struct packed
      {
         opcode_t     opcode;
         regbits_t    rs;
         regbits_t    rt;
         logic [15:0] imm;
      } i;
   } instr_u;

endpackage

/* mips_decode.sv */
//*********************************************************************
// fetch and decode stages
// imem_addr carries the next PC, the ROM answers one edge later
// branches are predicted not taken, execute redirects on a taken one
// fetch stops for good once a halt leaves decode
//*********************************************************************
`include "mips_config.svh"

module mips_decode
(
   input  logic               CLK,
   input  logic               nRST,
   output mips_pkg::word_t    imem_addr,
   input  mips_pkg::word_t    imem_data,
   input  logic               branch_taken,
   input  mips_pkg::word_t    branch_target,
   input  logic               mem_stall,
   input  logic               ex_load,
   input  mips_pkg::regbits_t ex_rt,
   output mips_pkg::regbits_t rsel1,
   output mips_pkg::regbits_t rsel2,
   input  mips_pkg::word_t    rdat1,
   input  mips_pkg::word_t    rdat2,
   output logic               id_valid,
   output mips_pkg::instr_u   id_instr,
   output mips_pkg::word_t    id_pc4,
   output mips_pkg::aluop_t   id_aluop,
   output logic               id_load,
   output logic               id_store,
   output logic               id_regwrite,
   output logic               id_alusrc,
   output logic               id_extop,
   output logic               id_branch,
   output logic               id_bne,
   output logic               id_halt,
   output mips_pkg::word_t    id_rdat1,
   output mips_pkg::word_t    id_rdat2
);
   import mips_pkg::*;

   word_t  pc;          // address of the word now on imem_data
   word_t  pc_next;
   logic   started;     // low for the first cycle out of reset
   logic   fetch_stop;
   logic   f_valid;
   logic   if_valid;
   instr_u if_instr;
   word_t  if_pc4;
   logic   uses_rs, uses_rt;
   logic   lu_stall;
   logic   hold;
   logic   halt_go;

   assign f_valid  = started & ~fetch_stop;
   assign hold     = mem_stall | lu_stall;
   assign halt_go  = if_valid & id_halt & ~branch_taken; // flushed halts don't count
   assign imem_addr = pc_next;

   always_comb
   begin
      if (mem_stall)
         pc_next = pc;                 // re-read, ROM data stays put
      else if (branch_taken)
         pc_next = branch_target;
      else if (lu_stall || !f_valid)
         pc_next = pc;
      else
         pc_next = pc + 32'd4;
   end

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         pc         <= `MIPS_PC_RESET;
         started    <= 1'b0;
         fetch_stop <= 1'b0;
         if_valid   <= 1'b0;
      end
      else
      begin
         pc      <= pc_next;
         started <= 1'b1;
         if (!hold)
         begin
            fetch_stop <= fetch_stop | halt_go;
            if_valid   <= f_valid & ~branch_taken & ~halt_go; // kill the younger word
         end
      end
   end

   // IF/ID payload
   always_ff @(posedge CLK)
   begin
      if (!hold)
      begin
         if_instr <= imem_data;
         if_pc4   <= pc + 32'd4;
      end
   end

   // control decode
   always_comb
   begin
      id_aluop    = ALU_ADD;
      id_load     = 1'b0;
      id_store    = 1'b0;
      id_regwrite = 1'b0;
      id_alusrc   = 1'b0;
      id_extop    = 1'b0;
      id_branch   = 1'b0;
      id_bne      = 1'b0;
      id_halt     = 1'b0;
      case (if_instr.r.opcode)
         RTYPE:
         begin
            id_regwrite = 1'b1;
            case (if_instr.r.funct)
               ADDU:    id_aluop = ALU_ADD;
               SUBU:    id_aluop = ALU_SUB;
               AND:     id_aluop = ALU_AND;
               OR:      id_aluop = ALU_OR;
               SLT:     id_aluop = ALU_SLT;
               SLL:     id_aluop = ALU_SLL;
               default: id_regwrite = 1'b0; // unsupported funct, no write
            endcase
         end
         ADDIU: {id_regwrite, id_alusrc, id_extop} = 3'b111;
         ANDI:
         begin
            {id_regwrite, id_alusrc} = 2'b11;
            id_aluop = ALU_AND;
         end
         ORI:
         begin
            {id_regwrite, id_alusrc} = 2'b11;
            id_aluop = ALU_OR;
         end
         LUI:
         begin
            {id_regwrite, id_alusrc} = 2'b11; // zero-extended imm shifted by 16
            id_aluop = ALU_SLL;
         end
         LW:      {id_load, id_regwrite, id_alusrc, id_extop} = 4'b1111;
         SW:      {id_store, id_alusrc, id_extop} = 3'b111;
         BEQ:     id_branch = 1'b1;
         BNE:     {id_branch, id_bne} = 2'b11;
         HALT:    id_halt = 1'b1;
         default: ;
      endcase
   end

   // which source fields are real reads
   assign uses_rs = (if_instr.i.opcode != LUI) && (if_instr.i.opcode != HALT);
   assign uses_rt = (if_instr.r.opcode == RTYPE) || id_store || id_branch;

   // load in execute feeding this instruction, one bubble
   assign lu_stall = if_valid & ex_load &
                     ((uses_rs && if_instr.r.rs == ex_rt) || (uses_rt && if_instr.r.rt == ex_rt));

   assign rsel1    = if_instr.r.rs;
   assign rsel2    = if_instr.r.rt;
   assign id_valid = if_valid & ~lu_stall;
   assign id_instr = if_instr;
   assign id_pc4   = if_pc4;
   assign id_rdat1 = rdat1;
   assign id_rdat2 = rdat2;

endmodule

/* mips_regfile.sv */
//*********************************************************************
// register file, two read ports and one write port
// register zero reads zero and ignores writes
// a write is visible on the read ports in the same cycle
//*********************************************************************
`include "mips_config.svh"

module mips_regfile
(
   input  logic               CLK,
   input  logic               nRST,
   input  mips_pkg::regbits_t rsel1,
   input  mips_pkg::regbits_t rsel2,
   output mips_pkg::word_t    rdat1,
   output mips_pkg::word_t    rdat2,
   input  logic               wen,
   input  mips_pkg::regbits_t wsel,
   input  mips_pkg::word_t    wdat
);
   import mips_pkg::*;

   word_t regs [`MIPS_REG_CNT];

   // zero register, then write bypass, then the array
   function automatic word_t rd_port(input regbits_t sel);
      if (sel == '0)
         return '0;
      if (wen && wsel == sel)
         return wdat;
      return regs[sel];
   endfunction

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         for (int i = 0; i < `MIPS_REG_CNT; i++)
            regs[i] <= '0;
      end
      else if (wen && wsel != '0)
         regs[wsel] <= wdat;
   end

   always_comb rdat1 = rd_port(rsel1);
   always_comb rdat2 = rd_port(rsel2);

endmodule

/* mips_execute.sv */
//*********************************************************************
// execute stage: ID/EX register, forwarding, ALU, branch resolve
// forwarding order is memory stage first, then writeback
// loads are never forwarded from memory, decode stalls for those
// operands refresh from forwarding while memory stalls
//*********************************************************************
module mips_execute
(
   input  logic               CLK,
   input  logic               nRST,
   input  logic               id_valid,
   input  mips_pkg::instr_u   id_instr,
   input  mips_pkg::word_t    id_pc4,
   input  mips_pkg::aluop_t   id_aluop,
   input  logic               id_load,
   input  logic               id_store,
   input  logic               id_regwrite,
   input  logic               id_alusrc,
   input  logic               id_extop,
   input  logic               id_branch,
   input  logic               id_bne,
   input  logic               id_halt,
   input  mips_pkg::word_t    id_rdat1,
   input  mips_pkg::word_t    id_rdat2,
   input  logic               mem_stall,
   input  logic               mem_fwd_valid,
   input  mips_pkg::regbits_t mem_fwd_reg,
   input  mips_pkg::word_t    mem_fwd_data,
   input  logic               wb_valid,
   input  mips_pkg::regbits_t wb_reg,
   input  mips_pkg::word_t    wb_data,
   output logic               ex_load,
   output mips_pkg::regbits_t ex_rt,
   output logic               branch_taken,
   output mips_pkg::word_t    branch_target,
   output logic               ex_valid,
   output mips_pkg::word_t    ex_result,
   output mips_pkg::word_t    ex_store_data,
   output mips_pkg::regbits_t ex_dest,
   output logic               ex_store,
   output logic               ex_regwrite,
   output logic               ex_halt
);
   import mips_pkg::*;

   logic       q_load, q_branch, q_bne, q_alusrc, q_extop;
   instr_u     q_instr;
   word_t      q_pc4;
   aluop_t     q_aluop;
   word_t      a_q, b_q;      // operand values as read or refreshed
   word_t      fwd_a, fwd_b;
   word_t      imm_sx, imm_ext, opb;
   logic [4:0] shamt;

   function automatic word_t fwd(input regbits_t src, input word_t rf_val);
      if (mem_fwd_valid && mem_fwd_reg == src)
         return mem_fwd_data;
      if (wb_valid && wb_reg == src)
         return wb_data;
      return rf_val;
   endfunction

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         ex_valid    <= 1'b0;
         q_load      <= 1'b0;
         ex_store    <= 1'b0;
         ex_regwrite <= 1'b0;
         q_branch    <= 1'b0;
         ex_halt     <= 1'b0;
      end
      else if (!mem_stall)
      begin
         ex_valid    <= id_valid & ~branch_taken; // taken branch squashes decode
         q_load      <= id_load;
         ex_store    <= id_store;
         ex_regwrite <= id_regwrite;
         q_branch    <= id_branch;
         ex_halt     <= id_halt;
      end
   end

   // ID/EX payload
   always_ff @(posedge CLK)
   begin
      if (mem_stall)
      begin
         a_q <= fwd_a; // keep a WB value that is about to leave
         b_q <= fwd_b;
      end
      else
      begin
         a_q      <= id_rdat1;
         b_q      <= id_rdat2;
         q_instr  <= id_instr;
         q_pc4    <= id_pc4;
         q_aluop  <= id_aluop;
         q_bne    <= id_bne;
         q_alusrc <= id_alusrc;
         q_extop  <= id_extop;
      end
   end

   always_comb fwd_a = fwd(q_instr.r.rs, a_q);
   always_comb fwd_b = fwd(q_instr.r.rt, b_q);

   assign imm_sx  = {{16{q_instr.i.imm[15]}}, q_instr.i.imm};
   assign imm_ext = q_extop ? imm_sx : {16'b0, q_instr.i.imm};
   assign opb     = q_alusrc ? imm_ext : fwd_b;
   assign shamt   = (q_instr.i.opcode == LUI) ? 5'd16 : q_instr.r.shamt; // lui = imm << 16

   always_comb
   begin
      case (q_aluop)
         ALU_ADD: ex_result = fwd_a + opb;
         ALU_SUB: ex_result = fwd_a - opb;
         ALU_AND: ex_result = fwd_a & opb;
         ALU_OR:  ex_result = fwd_a | opb;
         ALU_SLT: ex_result = word_t'($signed(fwd_a) < $signed(opb));
         ALU_SLL: ex_result = opb << shamt;
         default: ex_result = '0;
      endcase
   end

   // beq on equal, bne on not equal
   assign branch_taken  = ex_valid & q_branch & ((fwd_a == fwd_b) ^ q_bne);
   assign branch_target = q_pc4 + {imm_sx[29:0], 2'b00};

   assign ex_dest       = (q_instr.r.opcode == RTYPE) ? q_instr.r.rd : q_instr.i.rt;
   assign ex_store_data = fwd_b;
   assign ex_load       = ex_valid & q_load;
   assign ex_rt         = q_instr.i.rt;

endmodule

/* mips_mem_access.sv */
//*********************************************************************
// memory stage: EX/MEM register and APB master for lw and sw
// every access takes a setup cycle, then access cycles until pready
// the pipeline from PC to EX/MEM holds while mem_stall is high
//*********************************************************************
module mips_mem_access
(
   input  logic               CLK,
   input  logic               nRST,
   input  logic               ex_valid,
   input  logic               ex_load,
   input  logic               ex_store,
   input  logic               ex_regwrite,
   input  logic               ex_halt,
   input  mips_pkg::word_t    ex_result,
   input  mips_pkg::word_t    ex_store_data,
   input  mips_pkg::regbits_t ex_dest,
   output logic               psel,
   output logic               penable,
   output logic               pwrite,
   output mips_pkg::word_t    paddr,
   output mips_pkg::word_t    pwdata,
   input  mips_pkg::word_t    prdata,
   input  logic               pready,
   output logic               mem_stall,
   output logic               mem_fwd_valid,
   output mips_pkg::regbits_t mem_fwd_reg,
   output mips_pkg::word_t    mem_fwd_data,
   output logic               m_valid,
   output logic               m_regwrite,
   output mips_pkg::regbits_t m_dest,
   output mips_pkg::word_t    m_data,
   output logic               m_halt
);
   import mips_pkg::*;

   logic  q_load, q_store;
   word_t q_result, q_sdata;
   logic  access;   // low is idle or setup, high is access phase
   logic  mem_op;

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         m_valid    <= 1'b0;
         q_load     <= 1'b0;
         q_store    <= 1'b0;
         m_regwrite <= 1'b0;
         m_halt     <= 1'b0;
         access     <= 1'b0;
      end
      else
      begin
         if (!mem_stall)
         begin
            m_valid    <= ex_valid;
            q_load     <= ex_load;
            q_store    <= ex_store;
            m_regwrite <= ex_regwrite;
            m_halt     <= ex_halt;
         end
         if (!access)
            access <= mem_op;     // setup -> access
         else if (pready)
            access <= 1'b0;       // done, next op starts with setup again
      end
   end

   always_ff @(posedge CLK)
   begin
      if (!mem_stall)
      begin
         q_result <= ex_result;
         q_sdata  <= ex_store_data;
         m_dest   <= ex_dest;
      end
   end

   assign mem_op    = m_valid & (q_load | q_store);
   assign mem_stall = mem_op & ~(access & pready);

   // address, direction and data held by the stall
   assign psel    = mem_op;
   assign penable = access;
   assign pwrite  = q_store;
   assign paddr   = q_result;
   assign pwdata  = q_sdata;

   assign m_data = q_load ? prdata : q_result;

   // ALU results only, load data arrives too late
   assign mem_fwd_valid = m_valid & m_regwrite & ~q_load & (m_dest != '0);
   assign mem_fwd_reg   = m_dest;
   assign mem_fwd_data  = q_result;

endmodule

/* mips_result.sv */
//*********************************************************************
// writeback stage: MEM/WB register and commit port
// a bubble enters while memory stalls, so each commit shows once
// halted is sticky until reset
//*********************************************************************
module mips_result
(
   input  logic               CLK,
   input  logic               nRST,
   input  logic               m_valid,
   input  logic               m_regwrite,
   input  mips_pkg::regbits_t m_dest,
   input  mips_pkg::word_t    m_data,
   input  logic               m_halt,
   input  logic               mem_stall,
   output logic               wb_valid,
   output mips_pkg::regbits_t wb_reg,
   output mips_pkg::word_t    wb_data,
   output logic               halted
);
   import mips_pkg::*;

   logic w_write; // valid and writing

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         w_write <= 1'b0;
         halted  <= 1'b0;
      end
      else
      begin
         w_write <= m_valid & m_regwrite & ~mem_stall;
         halted  <= halted | (m_valid & m_halt & ~mem_stall); // halt now in writeback
      end
   end

   always_ff @(posedge CLK)
   begin
      wb_reg  <= m_dest;
      wb_data <= m_data;
   end

   assign wb_valid = w_write & (wb_reg != '0); // $zero never commits

endmodule

/* mips_core.sv */
//*********************************************************************
// pipelined MIPS subset core, top level
// instruction ROM with one cycle read latency on imem_*
// data memory on an APB master port, any number of wait states
// one commit per register write on wb_*
//*********************************************************************
module mips_core
(
   input  logic               CLK,
   input  logic               nRST,
   output mips_pkg::word_t    imem_addr,
   input  mips_pkg::word_t    imem_data,
   output logic               psel,
   output logic               penable,
   output logic               pwrite,
   output mips_pkg::word_t    paddr,
   output mips_pkg::word_t    pwdata,
   input  mips_pkg::word_t    prdata,
   input  logic               pready,
   output logic               wb_valid,
   output mips_pkg::regbits_t wb_reg,
   output mips_pkg::word_t    wb_data,
   output logic               halted
);
   import mips_pkg::*;

   regbits_t rsel1, rsel2, ex_rt, ex_dest, mem_fwd_reg, m_dest;
   word_t    rdat1, rdat2, id_rdat1, id_rdat2, id_pc4, branch_target;
   word_t    ex_result, ex_store_data, mem_fwd_data, m_data;
   instr_u   id_instr;
   aluop_t   id_aluop;
   logic     id_valid, id_load, id_store, id_regwrite, id_alusrc, id_extop;
   logic     id_branch, id_bne, id_halt;
   logic     branch_taken, mem_stall, ex_load, ex_valid, ex_store, ex_regwrite, ex_halt;
   logic     mem_fwd_valid, m_valid, m_regwrite, m_halt;

   mips_decode i_decode
   (
      .CLK, .nRST, .imem_addr, .imem_data, .branch_taken, .branch_target,
      .mem_stall, .ex_load, .ex_rt, .rsel1, .rsel2, .rdat1, .rdat2,
      .id_valid, .id_instr, .id_pc4, .id_aluop, .id_load, .id_store,
      .id_regwrite, .id_alusrc, .id_extop, .id_branch, .id_bne, .id_halt,
      .id_rdat1, .id_rdat2
   );

   // writeback port doubles as the write port
   mips_regfile i_regfile
   (
      .CLK, .nRST, .rsel1, .rsel2, .rdat1, .rdat2,
      .wen(wb_valid), .wsel(wb_reg), .wdat(wb_data)
   );

   mips_execute i_execute
   (
      .CLK, .nRST, .id_valid, .id_instr, .id_pc4, .id_aluop, .id_load,
      .id_store, .id_regwrite, .id_alusrc, .id_extop, .id_branch, .id_bne,
      .id_halt, .id_rdat1, .id_rdat2, .mem_stall, .mem_fwd_valid,
      .mem_fwd_reg, .mem_fwd_data, .wb_valid, .wb_reg, .wb_data, .ex_load,
      .ex_rt, .branch_taken, .branch_target, .ex_valid, .ex_result,
      .ex_store_data, .ex_dest, .ex_store, .ex_regwrite, .ex_halt
   );

   mips_mem_access i_mem_access
   (
      .CLK, .nRST, .ex_valid, .ex_load, .ex_store, .ex_regwrite, .ex_halt,
      .ex_result, .ex_store_data, .ex_dest, .psel, .penable, .pwrite, .paddr,
      .pwdata, .prdata, .pready, .mem_stall, .mem_fwd_valid, .mem_fwd_reg,
      .mem_fwd_data, .m_valid, .m_regwrite, .m_dest, .m_data, .m_halt
   );

   mips_result i_result
   (
      .CLK, .nRST, .m_valid, .m_regwrite, .m_dest, .m_data, .m_halt,
      .mem_stall, .wb_valid, .wb_reg, .wb_data, .halted
   );

endmodule

/* mips_core_tb.sv */
//*********************************************************************
// testbench for mips_core
// program, data image and expected results come from
// mips_core_vectors.txt, program words load from the reset PC upward
// ROM holds 64 words, data memory 256 words at byte address 0
// APB slave inserts 0 to 3 wait states from a seeded $random
// run ends on halted or on a cycle limit set by the program size
//*********************************************************************
`include "mips_config.svh"

module mips_core_tb;
   import mips_pkg::*;

   localparam int ROM_WORDS = 64;
   localparam int RAM_WORDS = 256;

   logic     CLK;
   logic     nRST;
   word_t    imem_addr;
   word_t    imem_data = '0;
   logic     psel, penable, pwrite;
   word_t    paddr, pwdata;
   word_t    prdata = '0;
   logic     pready = 1'b0;
   logic     wb_valid;
   regbits_t wb_reg;
   word_t    wb_data;
   logic     halted;

   word_t    rom [ROM_WORDS];
   word_t    ram [RAM_WORDS];
   regbits_t exp_reg [$];       // commits, in program order
   word_t    exp_wdata [$];
   word_t    exp_addr [$];      // APB writes, in order
   word_t    exp_sdata [$];
   int       write_errs = 0;
   int       store_errs = 0;
   int       other_errs = 0;
   int       cycles = 0;
   int       cycle_limit = 0;
   integer   seed = 32'h3b0f;
   int       waits = 0;         // wait states left in this transfer
   word_t    setup_addr, setup_wdata;
   logic     setup_write;
   bit       loaded;

   mips_core i_mips_core (.*);

   initial CLK = 1'b0;
   always #50 CLK = ~CLK;

   task automatic read_vectors(output bit ok);
      int     fd;
      int     n;
      int     pc_words;
      int     mem_ops;
      string  line;
      string  rest;
      byte    tag;
      word_t  a, b;
      instr_u iw;
      ok       = 1'b0;
      pc_words = 0;
      mem_ops  = 0;
      foreach (ram[i])
         ram[i] = 32'ha5000000 | (i << 2); // unwritten words show their address
      foreach (rom[i])
         rom[i] = '0;                      // sll $0 as filler
      fd = $fopen("mips_core_vectors.txt", "r");
      if (fd != 0)
      begin
         ok = 1'b1;
         while (!$feof(fd))
         begin
            line = "";
            n    = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#")
            begin
               a    = '0;
               b    = '0;
               tag  = line.getc(0);
               rest = line.substr(1, line.len() - 1);
               n    = $sscanf(rest, "%h %h", a, b);
               case (tag)
                  "P":
                  begin
                     iw = a;
                     if (iw.i.opcode == LW || iw.i.opcode == SW)
                        mem_ops++;
                     if (pc_words < ROM_WORDS)
                        rom[pc_words[5:0]] = a;
                     else
                     begin
                        $display("program does not fit in the %0d word ROM", ROM_WORDS);
                        other_errs++;
                     end
                     pc_words++;
                  end
                  "M": ram[a[9:2]] = b;
                  "W":
                  begin
                     exp_reg.push_back(a[4:0]);
                     exp_wdata.push_back(b);
                  end
                  "S":
                  begin
                     exp_addr.push_back(a);
                     exp_sdata.push_back(b);
                  end
                  default:
                  begin
                     $display("unknown line in vectors file: %s", line);
                     other_errs++;
                  end
               endcase
            end
         end
         $fclose(fd);
      end
      cycle_limit = 10 + 20 * pc_words + 4 * mem_ops; // reset, per word, per access
   endtask

   task automatic check_write(input regbits_t got_reg, input word_t got_data);
      regbits_t want_reg;
      word_t    want_data;
      if (exp_reg.size() == 0)
      begin
         $display("unexpected write of %h to r%0d at time %0t", got_data, got_reg, $time);
         write_errs++;
      end
      else
      begin
         want_reg  = exp_reg.pop_front();
         want_data = exp_wdata.pop_front();
         if (got_reg !== want_reg)
         begin
            $display("Mismatch at time %0t: wb_reg expected %0d, got %0d",
                     $time, want_reg, got_reg);
            write_errs++;
         end
         if (got_data !== want_data)
         begin
            $display("Mismatch at time %0t: wb_data expected %h, got %h",
                     $time, want_data, got_data);
            write_errs++;
         end
      end
   endtask

   task automatic check_store(input word_t got_addr, input word_t got_data);
      word_t want_addr;
      word_t want_data;
      if (exp_addr.size() == 0)
      begin
         $display("unexpected store of %h to %h at time %0t", got_data, got_addr, $time);
         store_errs++;
      end
      else
      begin
         want_addr = exp_addr.pop_front();
         want_data = exp_sdata.pop_front();
         if (got_addr !== want_addr)
         begin
            $display("Mismatch at time %0t: paddr expected %h, got %h",
                     $time, want_addr, got_addr);
            store_errs++;
         end
         if (got_data !== want_data)
         begin
            $display("Mismatch at time %0t: pwdata expected %h, got %h",
                     $time, want_data, got_data);
            store_errs++;
         end
      end
   endtask

   task automatic report_missing();
      if (exp_reg.size() != 0)
      begin
         $display("%0d expected register writes never committed", exp_reg.size());
         write_errs += exp_reg.size();
      end
      if (exp_addr.size() != 0)
      begin
         $display("%0d expected stores never reached the APB bus", exp_addr.size());
         store_errs += exp_addr.size();
      end
   endtask

   // instruction ROM, one cycle latency
   always @(posedge CLK)
   begin
      imem_data <= rom[imem_addr[7:2]];
      if (nRST && imem_addr[31:8] != '0)
      begin
         $display("fetch address %h lies outside the ROM at time %0t", imem_addr, $time);
         other_errs++;
      end
   end

   // APB slave on the data memory
   always @(posedge CLK)
   begin : apb_slave
      int draw;
      draw = 0;
      if (psel && !penable)
      begin
         draw        = $random(seed) & 3;  // wait states for this transfer
         waits       <= draw;
         pready      <= (draw == 0);
         prdata      <= ram[paddr[9:2]];
         setup_addr  <= paddr;
         setup_write <= pwrite;
         setup_wdata <= pwdata;
      end
      else if (psel && penable)
      begin
         if (paddr !== setup_addr || pwrite !== setup_write ||
             (pwrite && pwdata !== setup_wdata))
         begin
            $display("APB address, direction or write data moved during a transfer at %0t",
                     $time);
            other_errs++;
         end
         if (!pready)
         begin
            waits  <= waits - 1;
            pready <= (waits == 1);
         end
         else
         begin
            pready <= 1'b0;
            if (paddr[31:10] != '0)
            begin
               $display("APB access to %h is outside the data memory", paddr);
               other_errs++;
            end
            if (pwrite)
            begin
               ram[paddr[9:2]] <= pwdata;
               check_store(paddr, pwdata);
            end
         end
      end
      else
         pready <= 1'b0;
   end

   // commit port
   always @(posedge CLK)
   begin
      if (wb_valid)
      begin
         if (halted)
         begin
            $display("register write committed after halt at time %0t", $time);
            other_errs++;
         end
         check_write(wb_reg, wb_data);
      end
   end

   always @(posedge CLK)
   begin
      cycles <= cycles + 1;
      if (!halted && cycles >= cycle_limit)
      begin
         $display("run timed out after %0d cycles before halt", cycles);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   initial
   begin
      nRST = 1'b0;
      read_vectors(loaded);
      if (!loaded)
      begin
         $display("cannot open mips_core_vectors.txt");
         $display("CHECKS FAILED");
         $finish;
      end
      else
      begin
         repeat (10) @(posedge CLK);
         nRST <= 1'b1;
         while (halted !== 1'b1)
            @(posedge CLK);
         repeat (4) @(posedge CLK); // late commits would show here
         report_missing();
         $display("errors: %0d register write, %0d store, %0d other",
                  write_errs, store_errs, other_errs);
         if (write_errs + store_errs + other_errs == 0)
            $display("ALL CHECKS PASSED");
         else
            $display("CHECKS FAILED");
         $finish;
      end
   end

endmodule

/* mips_core_vectors.txt */
# P word: program words from the reset PC up. M addr data: initial data memory.
# W reg data: expected commits in order. S addr data: expected APB writes in order.
P 24010005
P 2402fffd
P 00221821
P 00612023
P 00812824
P 00a33025
P 0041382a
P 0022402a
P 00064900
P 3c0a1234
P 354aabcd
P 314bff0f
P 240c0040
P ad8a0000
P ad890004
P 8d8d0000
P 01a17021
P 8d8f0008
P 01ed8023
P 00210021
P 10250002
P 24110001
P 24120002
P 14250002
P 24130003
P 14e80002
P 24140004
P 24150005
P 10220002
P 0267b021
P ad96000c
P 8d97000c
P 0017c080
P ffffffff
P 24190009
M 00000040 11111111
M 00000048 cafe0001
M 0000004c 0badf00d
W 01 00000005
W 02 fffffffd
W 03 00000002
W 04 fffffffd
W 05 00000005
W 06 00000007
W 07 00000001
W 08 00000000
W 09 00000070
W 0a 12340000
W 0a 1234abcd
W 0b 0000ab0d
W 0c 00000040
W 0d 1234abcd
W 0e 1234abd2
W 0f cafe0001
W 10 b8c95434
W 13 00000003
W 16 00000004
W 17 00000004
W 18 00000010
S 00000040 1234abcd
S 00000044 00000070
S 0000004c 00000004

/* mips_core.f */
+incdir+.
mips_pkg.sv
mips_decode.sv
mips_regfile.sv
mips_execute.sv
mips_mem_access.sv
mips_result.sv
mips_core.sv
mips_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the mips_core testbench with Verilator
# exit status is 0 only when the run prints the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f mips_core.f --top-module mips_core_tb -o mips_core_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/mips_core_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
   exit 0
fi
exit 1
